//--- qdr_phy_cfg.svh
`ifndef QDR_PHY_CFG_SVH
`define QDR_PHY_CFG_SVH

`define QDR_DATA_WIDTH 36   // read data lines
`define QDR_TAP_BITS   5    // 32 taps per delay line

// delay tap size and capture hold time, in ps
`define QDR_DLY_DELTA  78
`define QDR_HOLD_TIME  400
`define QDR_BIT_STEPS  (`QDR_HOLD_TIME / `QDR_DLY_DELTA + 1)

`define QDR_HIST_LEN   3    // earlier samples that must agree
`define QDR_ACQ_CYCLES 16   // settle, then the same again to watch

`endif

//--- qdr_train_pkg.sv
package qdr_train_pkg;

  `include "qdr_phy_cfg.svh"

  typedef logic [`QDR_TAP_BITS-1:0] tap_t;                  // tap position or step count
  typedef logic [$clog2(`QDR_DATA_WIDTH)-1:0] line_idx_t;
  typedef logic [1:0] sample_pair_t;                         // {rise, fall}

  typedef enum logic [2:0] {
    ST_IDLE,
    ST_SEARCH,
    ST_BACK,
    ST_FORWARD,
    ST_ALIGN,
    ST_DONE
  } train_state_t;

  typedef enum logic {
    MODE_STEP,
    MODE_ACQUIRE
  } acq_mode_t;

  // a real data bit always toggles between the two edges
  function automatic logic sample_valid(sample_pair_t s);
    return s[1] ^ s[0];
  endfunction

endpackage

//--- qdr_data_pkg.sv
package qdr_data_pkg;

  `include "qdr_phy_cfg.svh"

  typedef logic [`QDR_DATA_WIDTH-1:0] data_word_t;
  typedef logic [`QDR_DATA_WIDTH-1:0] line_mask_t;

  typedef struct packed {
    data_word_t rise;
    data_word_t fall;
  } read_beat_t;

  typedef struct packed {
    line_mask_t en;   // one-hot step pulse
    line_mask_t rst;  // back to tap 0
    logic       inc;  // step direction, 1 = later
  } dly_ctrl_t;

endpackage

//--- qdr_read_capture.sv
`timescale 1ns/1ns

module qdr_read_capture
  import qdr_data_pkg::*;
  import qdr_train_pkg::*;
(
  input  logic         clk,
  input  logic         reset,
  input  read_beat_t   q,
  input  line_idx_t    line_sel,
  output read_beat_t   beat_sync,
  output sample_pair_t sample
);

  read_beat_t q_meta;   // first stage after the capture flops
  read_beat_t q_sync;
  line_idx_t  sel_d1;
  line_idx_t  sel_d2;

  assign beat_sync = q_sync;

  always_ff @(posedge clk) begin
    if (reset) begin
      q_meta <= '0;
      q_sync <= '0;
    end else begin
      q_meta <= q;
      q_sync <= q_meta;
    end
  end

  // select goes through two stages, sample lands 3 cycles after a change
  always_ff @(posedge clk) begin
    if (reset) begin
      sel_d1 <= '0;
      sel_d2 <= '0;
      sample <= '0;
    end else begin
      sel_d1 <= line_sel;
      sel_d2 <= sel_d1;
      sample <= {q_sync.rise[sel_d2], q_sync.fall[sel_d2]};
    end
  end

endmodule

//--- qdr_bit_train.sv
`timescale 1ns/1ns

`include "qdr_phy_cfg.svh"

module qdr_bit_train
  import qdr_train_pkg::*;
(
  input  logic         clk,
  input  logic         reset,
  input  logic         train_start,
  input  sample_pair_t sample,
  output line_idx_t    line_sel,
  output logic         step_en,
  output logic         step_inc,
  output logic         dly_reset_line,
  output logic         align_wr,
  output logic         align_val,
  output logic         train_done,
  output logic         train_fail,
  output train_state_t state_probe
);

  localparam int BIT_STEPS = `QDR_BIT_STEPS;
  localparam int HIST      = `QDR_HIST_LEN;
  localparam int ACQ       = `QDR_ACQ_CYCLES;
  localparam int TAP_COUNT = 1 << `QDR_TAP_BITS;
  localparam tap_t      TAP_MAX   = '1;
  localparam line_idx_t LAST_LINE = line_idx_t'(`QDR_DATA_WIDTH - 1);

  train_state_t state;
  acq_mode_t    mode;
  logic [$clog2(2*ACQ)-1:0] acq_cnt;

  sample_pair_t curr;          // value taken by the last acquire
  sample_pair_t first_val;     // first stable value of this line
  sample_pair_t hist [HIST];
  tap_t         progress;
  tap_t         baddies;       // unstable acquires after the first stable one
  logic         hist_stable;

  assign state_probe = state;

  always_comb begin
    hist_stable = sample_valid(curr);
    for (int i = 0; i < HIST; i++)
      hist_stable = hist_stable && (hist[i] == curr);
  end

  always_ff @(posedge clk) begin
    step_en        <= 1'b0;
    dly_reset_line <= 1'b0;
    align_wr       <= 1'b0;
    if (reset) begin
      state      <= ST_IDLE;
      mode       <= MODE_STEP;
      acq_cnt    <= '0;
      line_sel   <= '0;
      step_inc   <= 1'b0;
      align_val  <= 1'b0;
      train_done <= 1'b0;
      train_fail <= 1'b0;
      curr       <= '0;
      first_val  <= '0;
      hist       <= '{default: '0};
      progress   <= '0;
      baddies    <= '0;
    end else if (mode == MODE_ACQUIRE) begin
      acq_cnt <= acq_cnt + 1'b1;
      if (acq_cnt < ACQ) begin
        if (acq_cnt == ACQ - 1)
          curr <= sample;                  // end of settle
      end else begin
        if (!sample_valid(sample) || sample != curr) begin
          curr <= '0;                      // mark as unusable
          mode <= MODE_STEP;
        end
        if (acq_cnt == 2 * ACQ - 1)
          mode <= MODE_STEP;
      end
    end else begin
      acq_cnt <= '0;
      case (state)
        ST_IDLE: begin
          if (train_start) begin
            state     <= ST_SEARCH;
            mode      <= MODE_ACQUIRE;
            progress  <= '0;
            baddies   <= '0;
            first_val <= '0;
            hist      <= '{default: '0};
          end
        end
        ST_SEARCH: begin
          mode    <= MODE_ACQUIRE;
          hist[0] <= curr;
          for (int i = HIST - 1; i > 0; i--)
            hist[i] <= hist[i-1];
          if (hist_stable && !sample_valid(first_val))
            first_val <= curr;
          if (sample_valid(first_val) && !hist_stable)
            baddies <= baddies + 1'b1;

          if (progress == TAP_MAX) begin   // ran out of taps, no edge
            state          <= ST_ALIGN;
            train_fail     <= 1'b1;
            dly_reset_line <= 1'b1;
          end else if (hist_stable && sample_valid(first_val) && first_val != curr) begin
            if (int'(progress) + BIT_STEPS - HIST < TAP_COUNT) begin
              state    <= ST_FORWARD;
              progress <= tap_t'(BIT_STEPS - HIST);
            end else begin
              state    <= ST_BACK;
              progress <= tap_t'(BIT_STEPS + int'(baddies) + HIST);
              if (BIT_STEPS + int'(baddies) + HIST > int'(progress))
                train_fail <= 1'b1;        // can't back off past tap 0
            end
          end else begin
            progress <= progress + 1'b1;
            step_inc <= 1'b1;
            step_en  <= 1'b1;
          end
        end
        ST_BACK, ST_FORWARD: begin
          mode <= MODE_ACQUIRE;
          if (progress != '0) begin
            progress <= progress - 1'b1;
            step_inc <= (state == ST_FORWARD);
            step_en  <= 1'b1;
          end else begin
            state <= ST_ALIGN;
            if (!sample_valid(curr))
              train_fail <= 1'b1;
          end
        end
        ST_ALIGN: begin
          state     <= ST_DONE;
          align_wr  <= 1'b1;
          align_val <= sample[1];          // rise bit tells the order
        end
        ST_DONE: begin
          if (line_sel != LAST_LINE) begin
            state     <= ST_SEARCH;
            mode      <= MODE_ACQUIRE;
            line_sel  <= line_sel + 1'b1;
            progress  <= '0;
            baddies   <= '0;
            first_val <= '0;
            hist      <= '{default: '0};
          end else begin
            train_done <= 1'b1;
          end
        end
        default: state <= ST_IDLE;
      endcase
    end
  end

  // steps and alignment writes share line_sel downstream
  a_step_align_excl: assert property (@(posedge clk) disable iff (reset)
    !(step_en && align_wr));

  a_line_in_range: assert property (@(posedge clk) disable iff (reset)
    line_sel < `QDR_DATA_WIDTH);

endmodule

//--- qdr_lane_align.sv
`timescale 1ns/1ns

module qdr_lane_align
  import qdr_data_pkg::*;
  import qdr_train_pkg::*;
(
  input  logic       clk,
  input  logic       reset,
  input  line_idx_t  line_sel,
  input  logic       step_en,
  input  logic       step_inc,
  input  logic       dly_reset_line,
  input  logic       align_wr,
  input  logic       align_val,
  input  read_beat_t beat_sync,
  output dly_ctrl_t  dly,
  output line_mask_t aligned,
  output read_beat_t rd_data
);

  always_ff @(posedge clk) begin
    dly.en  <= '0;       // pulses last one cycle
    dly.rst <= '0;
    if (reset) begin
      dly.rst <= '1;     // all delay lines back to tap 0
      dly.inc <= 1'b0;
      aligned <= '1;
    end else begin
      if (step_en) begin
        dly.en[line_sel] <= 1'b1;
        dly.inc          <= step_inc;
      end
      if (dly_reset_line)
        dly.rst[line_sel] <= 1'b1;
      if (align_wr)
        aligned[line_sel] <= align_val;
    end
  end

  // swapped lines get rise and fall exchanged
  always_ff @(posedge clk) begin
    rd_data.rise <= (beat_sync.rise & aligned) | (beat_sync.fall & ~aligned);
    rd_data.fall <= (beat_sync.fall & aligned) | (beat_sync.rise & ~aligned);
  end

  // a step and a line reset never go out together
  a_en_onehot: assert property (@(posedge clk) disable iff (reset)
    !$past(reset) |-> $onehot0({dly.en, dly.rst}));

endmodule

//--- qdr_phy_read.sv
`timescale 1ns/1ns

module qdr_phy_read
  import qdr_data_pkg::*;
  import qdr_train_pkg::*;
(
  input  logic         clk,
  input  logic         reset,
  input  logic         train_start,
  input  read_beat_t   q,
  output dly_ctrl_t    dly,
  output line_mask_t   aligned,
  output read_beat_t   rd_data,
  output logic         train_done,
  output logic         train_fail,
  output train_state_t state_probe
);

  read_beat_t   beat_sync;
  sample_pair_t sample;
  line_idx_t    line_sel;
  logic         step_en;
  logic         step_inc;
  logic         dly_reset_line;
  logic         align_wr;
  logic         align_val;

  qdr_read_capture u_capture (
    .clk       (clk),
    .reset     (reset),
    .q         (q),
    .line_sel  (line_sel),
    .beat_sync (beat_sync),
    .sample    (sample)
  );

  qdr_bit_train u_train (
    .clk            (clk),
    .reset          (reset),
    .train_start    (train_start),
    .sample         (sample),
    .line_sel       (line_sel),
    .step_en        (step_en),
    .step_inc       (step_inc),
    .dly_reset_line (dly_reset_line),
    .align_wr       (align_wr),
    .align_val      (align_val),
    .train_done     (train_done),
    .train_fail     (train_fail),
    .state_probe    (state_probe)
  );

  qdr_lane_align u_align (
    .clk            (clk),
    .reset          (reset),
    .line_sel       (line_sel),
    .step_en        (step_en),
    .step_inc       (step_inc),
    .dly_reset_line (dly_reset_line),
    .align_wr       (align_wr),
    .align_val      (align_val),
    .beat_sync      (beat_sync),
    .dly            (dly),
    .aligned        (aligned),
    .rd_data        (rd_data)
  );

endmodule

//--- qdr_line_model.sv
`timescale 1ns/1ns

`include "qdr_phy_cfg.svh"

module qdr_line_model
  import qdr_data_pkg::*;
  import qdr_train_pkg::*;
(
  input  logic                             clk,
  input  dly_ctrl_t                        dly,
  input  logic [`QDR_DATA_WIDTH-1:0][5:0]  edge_tap,   // tap where the eye closes
  input  line_mask_t                       phase,      // 1 = rise high below the edge
  input  logic                             data_mode,
  input  read_beat_t                       data,
  output read_beat_t                       q
);

  tap_t       tap [`QDR_DATA_WIDTH];
  read_beat_t noise;
  integer     seed = 32'h39d4;

  always @(posedge clk) begin : noise_gen
    logic [95:0] rnd;
    rnd = {$random(seed), $random(seed), $random(seed)};
    noise <= rnd[71:0];   // new pair every cycle on the edge tap
  end

  // behavioral delay lines
  always @(posedge clk) begin
    for (int i = 0; i < `QDR_DATA_WIDTH; i++) begin
      if (dly.rst[i])
        tap[i] <= '0;
      else if (dly.en[i] && dly.inc && tap[i] != '1)
        tap[i] <= tap[i] + 1'b1;
      else if (dly.en[i] && !dly.inc && tap[i] != '0)
        tap[i] <= tap[i] - 1'b1;
    end
  end

  always_comb begin
    logic r;
    for (int i = 0; i < `QDR_DATA_WIDTH; i++) begin
      r = (6'(tap[i]) < edge_tap[i]) ? phase[i] : ~phase[i];
      if (data_mode) begin
        // data lands swapped wherever the pattern's rise is low
        q.rise[i] = r ? data.rise[i] : data.fall[i];
        q.fall[i] = r ? data.fall[i] : data.rise[i];
      end else if (6'(tap[i]) == edge_tap[i]) begin
        q.rise[i] = noise.rise[i];
        q.fall[i] = noise.fall[i];
      end else begin
        q.rise[i] = r;
        q.fall[i] = ~r;
      end
    end
  end

endmodule

//--- qdr_phy_tb.sv
`timescale 1ns/1ns

`include "qdr_phy_cfg.svh"

module qdr_phy_tb
  import qdr_data_pkg::*;
  import qdr_train_pkg::*;
();

  localparam int W              = `QDR_DATA_WIDTH;
  localparam int TAPS           = 1 << `QDR_TAP_BITS;
  localparam int TRAIN_CYCLES   = W * 40 * 34;          // lines x steps x cycles per step
  localparam int TIMEOUT_CYCLES = 3 * TRAIN_CYCLES + 2000;
  localparam int NO_EDGE_LINE   = 13;

  logic         clk;
  logic         reset;
  logic         train_start;
  logic         data_mode;
  read_beat_t   q;
  read_beat_t   data;
  read_beat_t   rd_data;
  dly_ctrl_t    dly;
  line_mask_t   aligned;
  line_mask_t   phase;
  logic         train_done;
  logic         train_fail;
  train_state_t state_probe;
  logic [W-1:0][5:0] edge_tap;

  integer     seed = 32'h39d4;
  int         errors = 0;
  int         checks = 0;
  int         cycles = 0;
  logic       started;          // train_start has been given since reset
  line_mask_t rst_seen;         // dly.rst pulses after train_start
  line_mask_t rst_at_release;

  qdr_phy_read dut (
    .clk         (clk),
    .reset       (reset),
    .train_start (train_start),
    .q           (q),
    .dly         (dly),
    .aligned     (aligned),
    .rd_data     (rd_data),
    .train_done  (train_done),
    .train_fail  (train_fail),
    .state_probe (state_probe)
  );

  qdr_line_model model (
    .clk       (clk),
    .dly       (dly),
    .edge_tap  (edge_tap),
    .phase     (phase),
    .data_mode (data_mode),
    .data      (data),
    .q         (q)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  task automatic check_mask(input line_mask_t got, input line_mask_t exp, input string what);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("MISMATCH at %0t ns: %s, got %h expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_beat(input read_beat_t got, input read_beat_t exp, input string what);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("MISMATCH at %0t ns: %s, got %h expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_flag(input logic got, input logic exp, input string what);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("MISMATCH at %0t ns: %s, got %b expected %b", $time, what, got, exp);
    end
  endtask

  task automatic check_state(input train_state_t got, input train_state_t exp,
                             input string what);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("MISMATCH at %0t ns: %s, got %0d expected %0d", $time, what, got, exp);
    end
  endtask

  task automatic finish_run();
    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  endtask

  // edge seen once the noisy tap has left the history
  function automatic int detect_tap(input int line);
    return int'(edge_tap[line]) + `QDR_HIST_LEN + 1;
  endfunction

  function automatic line_mask_t mask_from_eyes();
    line_mask_t m;
    int d;
    for (int i = 0; i < W; i++) begin
      d = detect_tap(i);
      if (d >= TAPS - 1)
        m[i] = phase[i];                                   // line reset to tap 0
      else if (d + `QDR_BIT_STEPS - `QDR_HIST_LEN < TAPS)
        m[i] = ~phase[i];                                  // centered past the edge
      else
        m[i] = phase[i];                                   // backed off below it
    end
    return m;
  endfunction

  function automatic logic fail_from_eyes();
    logic f;
    f = 1'b0;
    for (int i = 0; i < W; i++)
      if (detect_tap(i) >= TAPS - 1)
        f = 1'b1;
    return f;
  endfunction

  task automatic apply_reset();
    reset    = 1'b1;
    started  = 1'b0;
    rst_seen = '0;
    repeat (8) @(posedge clk);
    #5;
    rst_at_release = dly.rst;
    reset = 1'b0;
    @(posedge clk);
    #5;
  endtask

  task automatic run_training(input string name);
    apply_reset();
    started     = 1'b1;
    train_start = 1'b1;
    @(posedge clk);
    #5;
    train_start = 1'b0;
    while (!train_done) begin   // watchdog ends the run if this never rises
      @(posedge clk);
      #5;
    end
    check_flag(train_fail, fail_from_eyes(), {name, " train_fail"});
    check_mask(aligned, mask_from_eyes(), {name, " aligned"});
    check_state(state_probe, ST_DONE, {name, " state"});
  endtask

  task automatic set_good_eye();
    for (int i = 0; i < W; i++) begin
      edge_tap[i] = 6'(4 + (i * 7) % 17);   // taps 4 to 20
      phase[i]    = (i % 3) != 0;
    end
  endtask

  task automatic reset_defaults();
    apply_reset();
    check_mask(rst_at_release, '1, "dly.rst during reset");
    check_mask(dly.rst, '0, "dly.rst after reset");
    check_mask(dly.en, '0, "dly.en after reset");
    check_mask(aligned, '1, "aligned after reset");
    check_flag(train_done, 1'b0, "train_done after reset");
    check_flag(train_fail, 1'b0, "train_fail after reset");
    check_state(state_probe, ST_IDLE, "state after reset");
  endtask

  task automatic good_eye_training();
    set_good_eye();
    run_training("good eye");
  endtask

  // 25 and 26 are the last edges still found before the tap range runs out
  task automatic late_edge_backoff();
    set_good_eye();
    for (int i = 0; i < W; i++)
      if (i % 7 == 3)
        edge_tap[i] = 6'(25 + i % 2);
    run_training("late edge");
  endtask

  task automatic missing_edge_failure();
    set_good_eye();
    edge_tap[NO_EDGE_LINE] = 6'h3f;   // beyond the last tap
    run_training("no edge");
    check_mask(rst_seen, line_mask_t'(1) << NO_EDGE_LINE, "dly.rst pulses");
  endtask

  task automatic realign_data(input int n);
    read_beat_t  sent [$];
    read_beat_t  beat;
    logic [95:0] rnd;
    data_mode = 1'b1;
    for (int k = 0; k < n + 3; k++) begin
      if (k >= 3)
        check_beat(rd_data, sent.pop_front(), "rd_data");   // two sync stages plus output reg
      if (k < n) begin
        rnd  = {$random(seed), $random(seed), $random(seed)};
        beat = rnd[71:0];
        data = beat;
        sent.push_back(beat);
      end
      @(posedge clk);
      #5;
    end
    data_mode = 1'b0;
  endtask

  always @(posedge clk) begin
    cycles = cycles + 1;
    if (!reset)
      check_flag($onehot0(dly.en), 1'b1, "dly.en at most one bit");
    if (!reset && !started)
      check_mask(dly.en, '0, "dly.en before train_start");
    if (started)
      rst_seen = rst_seen | dly.rst;
    if (cycles == TIMEOUT_CYCLES) begin
      $display("timeout after %0d cycles, training never finished", cycles);
      errors++;
      finish_run();
    end
  end

  initial begin
    reset       = 1'b1;
    train_start = 1'b0;
    data_mode   = 1'b0;
    data        = '0;
    phase       = '0;
    edge_tap    = '0;
    started     = 1'b0;
    rst_seen    = '0;
    reset_defaults();
    good_eye_training();
    realign_data(40);
    late_edge_backoff();
    realign_data(40);
    missing_edge_failure();
    realign_data(40);
    finish_run();
  end

endmodule

//--- verilog.f
+incdir+.
qdr_train_pkg.sv
qdr_data_pkg.sv
qdr_read_capture.sv
qdr_bit_train.sv
qdr_lane_align.sv
qdr_phy_read.sv
qdr_line_model.sv
qdr_phy_tb.sv

//--- run_sim.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f verilog.f \
  --top-module qdr_phy_tb -o qdr_phy_sim
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/qdr_phy_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "^=== PASS ===$" sim.log; then
  exit 0
fi
echo "pass message not found in sim.log"
exit 1
